/* src/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// mtime window of the local timer block
`define LSU_CLINT_BASE   32'ha0000048
`define LSU_CLINT_END    32'ha000004f

// word offsets of the two mtime halves inside the window
`define LSU_MTIME_LO_OFS 32'd0
`define LSU_MTIME_HI_OFS 32'd4

// AXI response codes
`define LSU_RESP_OKAY    2'b00
`define LSU_RESP_SLVERR  2'b10

`endif

/* src/lsu_req_pkg.sv */
`default_nettype none

package lsu_req_pkg;

    // encoding matches the AXI size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef struct packed {
        logic [31:0]  addr;
        logic [31:0]  wdata;
        access_size_e size;
        logic         write;
        logic         sign;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

    // what the merge stage needs to shape load data
    typedef struct packed {
        logic [1:0]   ofs;
        access_size_e size;
        logic         sign;
    } load_fmt_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } mtime_words_t;

    typedef union packed {
        logic [63:0]  full;
        mtime_words_t words;
    } mtime_u;

    // byte strobe of an aligned access
    function automatic logic [3:0] size_strb(access_size_e size, logic [1:0] ofs);
        case (size)
            SIZE_BYTE: size_strb = 4'b0001 << ofs;
            SIZE_HALF: size_strb = 4'b0011 << ofs;
            default:   size_strb = 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    // write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_aw_t;

    // write data channel, single beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_ar_t;

    // read data channel, single beat
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

endpackage

`default_nettype wire

/* src/lsu_req_route.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_req_route (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire lsu_req_pkg::mem_req_t req,
    output logic                     axi_go_valid,
    input  wire                      axi_go_ready,
    output lsu_req_pkg::mem_req_t    axi_go,
    output logic                     clint_go_valid,
    input  wire                      clint_go_ready,
    output logic [31:0]              clint_go_wdata,
    output logic                     clint_go_hi,
    output logic                     clint_go_write,
    output logic                     clint_go_err,
    output lsu_req_pkg::load_fmt_t   fmt,
    input  wire                      retire
);
    import lsu_req_pkg::*;

    typedef enum logic [1:0] {S_INIT, S_IDLE, S_DISP, S_WAIT} state_e;

    state_e      state;
    logic        in_clint;
    logic        in_clint_q;
    logic [31:0] clint_ofs;
    logic [3:0]  strb;
    logic [31:0] lane_data;

    // address decode and lane shaping
    always_comb begin
        in_clint  = (req.addr >= `LSU_CLINT_BASE) && (req.addr <= `LSU_CLINT_END);
        clint_ofs = req.addr - `LSU_CLINT_BASE;
        strb      = size_strb(req.size, req.addr[1:0]);
        lane_data = req.wdata << {req.addr[1:0], 3'b000};
        for (int i = 0; i < 4; i++) begin
            if (!strb[i]) begin
                lane_data[8*i +: 8] = 8'h00;
            end
        end
    end

    assign req_ready      = (state == S_IDLE);
    assign axi_go_valid   = (state == S_DISP) && !in_clint_q;
    assign clint_go_valid = (state == S_DISP) && in_clint_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_INIT;
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: if (req_valid) state <= S_DISP;
                S_DISP: begin
                    if ((axi_go_valid && axi_go_ready) || (clint_go_valid && clint_go_ready)) begin
                        state <= S_WAIT;
                    end
                end
                // busy until the response has left the unit
                S_WAIT: if (retire) state <= S_IDLE;
                default: state <= S_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            in_clint_q     <= in_clint;
            axi_go.addr    <= req.addr;
            axi_go.wdata   <= lane_data;
            axi_go.size    <= req.size;
            axi_go.write   <= req.write;
            axi_go.sign    <= req.sign;
            clint_go_wdata <= lane_data;
            clint_go_hi    <= ({clint_ofs[31:2], 2'b00} == `LSU_MTIME_HI_OFS);
            clint_go_write <= req.write;
            // mtime only takes whole words
            clint_go_err   <= in_clint && req.write && (req.size != SIZE_WORD);
            fmt.ofs        <= req.addr[1:0];
            fmt.size       <= req.size;
            fmt.sign       <= req.sign;
        end
    end

endmodule

`default_nettype wire

/* src/lsu_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_axi_master (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        go_valid,
    output logic                       go_ready,
    input  wire lsu_req_pkg::mem_req_t go,
    output logic                       aw_valid,
    input  wire                        aw_ready,
    output axi_lite_pkg::axi_aw_t      aw,
    output logic                       w_valid,
    input  wire                        w_ready,
    output axi_lite_pkg::axi_w_t       w,
    input  wire                        b_valid,
    output logic                       b_ready,
    input  wire axi_lite_pkg::axi_b_t  b,
    output logic                       ar_valid,
    input  wire                        ar_ready,
    output axi_lite_pkg::axi_ar_t      ar,
    input  wire                        r_valid,
    output logic                       r_ready,
    input  wire axi_lite_pkg::axi_r_t  r,
    output logic                       res_valid,
    input  wire                        res_ready,
    output lsu_req_pkg::mem_rsp_t      res
);
    import lsu_req_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WR, S_RD, S_RES} state_e;

    state_e state;

    // single beat, so responses are always accepted
    assign b_ready   = 1'b1;
    assign r_ready   = 1'b1;
    assign go_ready  = (state == S_IDLE);
    assign res_valid = (state == S_RES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (go_valid) begin
                        if (go.write) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= S_WR;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= S_RD;
                        end
                    end
                end
                S_WR: begin
                    // address and data complete independently
                    if (aw_valid && aw_ready) aw_valid <= 1'b0;
                    if (w_valid && w_ready) w_valid <= 1'b0;
                    if (b_valid && b_ready) state <= S_RES;
                end
                S_RD: begin
                    if (ar_valid && ar_ready) ar_valid <= 1'b0;
                    if (r_valid && r_ready) state <= S_RES;
                end
                S_RES: begin
                    if (res_ready) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (go_valid && go_ready) begin
            aw.addr <= go.addr;
            aw.size <= {1'b0, go.size};
            w.data  <= go.wdata;
            w.strb  <= size_strb(go.size, go.addr[1:0]);
            ar.addr <= go.addr;
            ar.size <= {1'b0, go.size};
        end
        if (state == S_WR && b_valid) begin
            res.rdata <= 32'd0;
            res.err   <= (b.resp != `LSU_RESP_OKAY);
        end
        if (state == S_RD && r_valid) begin
            res.rdata <= r.data;
            res.err   <= (r.resp != `LSU_RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

/* src/lsu_clint.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_clint (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   go_valid,
    output logic                  go_ready,
    input  wire [31:0]            go_wdata,
    input  wire                   go_hi,
    input  wire                   go_write,
    input  wire                   go_err,
    output logic                  res_valid,
    input  wire                   res_ready,
    output lsu_req_pkg::mem_rsp_t res
);
    import lsu_req_pkg::*;

    mtime_u mtime;
    logic   go_fire;
    logic   do_write;

    assign go_fire  = go_valid && go_ready;
    assign do_write = go_fire && go_write && !go_err;
    // one result slot
    assign go_ready = !res_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime.full <= 64'd0;
        end else if (do_write) begin
            // the tick of this cycle is dropped
            if (go_hi) begin
                mtime.words.hi <= go_wdata;
            end else begin
                mtime.words.lo <= go_wdata;
            end
        end else begin
            mtime.full <= mtime.full + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (go_fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (go_fire) begin
            res.rdata <= go_write ? 32'd0 : (go_hi ? mtime.words.hi : mtime.words.lo);
            res.err   <= go_err;
        end
    end

endmodule

`default_nettype wire

/* src/lsu_rsp_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_rsp_merge (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire lsu_req_pkg::load_fmt_t  fmt,
    input  wire                          axi_res_valid,
    input  wire lsu_req_pkg::mem_rsp_t   axi_res,
    input  wire                          clint_res_valid,
    input  wire lsu_req_pkg::mem_rsp_t   clint_res,
    output logic                         res_ready,
    output logic                         rsp_valid,
    input  wire                          rsp_ready,
    output lsu_req_pkg::mem_rsp_t        rsp,
    output logic                         retire
);
    import lsu_req_pkg::*;

    mem_rsp_t    sel;
    logic [31:0] shifted;
    logic [31:0] ext;
    logic        take;

    always_comb begin
        // only one side is ever active
        sel     = clint_res_valid ? clint_res : axi_res;
        shifted = sel.rdata >> {fmt.ofs, 3'b000};
        case (fmt.size)
            SIZE_BYTE: ext = {{24{fmt.sign & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: ext = {{16{fmt.sign & shifted[15]}}, shifted[15:0]};
            default:   ext = shifted;
        endcase
    end

    assign res_ready = !rsp_valid;
    assign take      = (axi_res_valid || clint_res_valid) && res_ready;
    assign retire    = rsp_valid && rsp_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp.rdata <= ext;
            rsp.err   <= sel.err;
        end
    end

endmodule

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire lsu_req_pkg::mem_req_t  req,
    output logic                        rsp_valid,
    input  wire                         rsp_ready,
    output lsu_req_pkg::mem_rsp_t       rsp,
    output logic                        aw_valid,
    input  wire                         aw_ready,
    output axi_lite_pkg::axi_aw_t       aw,
    output logic                        w_valid,
    input  wire                         w_ready,
    output axi_lite_pkg::axi_w_t        w,
    input  wire                         b_valid,
    output logic                        b_ready,
    input  wire axi_lite_pkg::axi_b_t   b,
    output logic                        ar_valid,
    input  wire                         ar_ready,
    output axi_lite_pkg::axi_ar_t       ar,
    input  wire                         r_valid,
    output logic                        r_ready,
    input  wire axi_lite_pkg::axi_r_t   r
);
    import lsu_req_pkg::*;

    // dispatch
    logic        axi_go_valid;
    logic        axi_go_ready;
    mem_req_t    axi_go;
    logic        clint_go_valid;
    logic        clint_go_ready;
    logic [31:0] clint_go_wdata;
    logic        clint_go_hi;
    logic        clint_go_write;
    logic        clint_go_err;
    load_fmt_t   fmt;
    // results
    logic        axi_res_valid;
    mem_rsp_t    axi_res;
    logic        clint_res_valid;
    mem_rsp_t    clint_res;
    logic        res_ready;
    logic        retire;

    lsu_req_route route_i (
        .clk, .arst_n, .req_valid, .req_ready, .req,
        .axi_go_valid, .axi_go_ready, .axi_go,
        .clint_go_valid, .clint_go_ready, .clint_go_wdata,
        .clint_go_hi, .clint_go_write, .clint_go_err, .fmt, .retire
    );

    lsu_axi_master axi_i (
        .clk, .arst_n,
        .go_valid (axi_go_valid), .go_ready (axi_go_ready), .go (axi_go),
        .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w,
        .b_valid, .b_ready, .b, .ar_valid, .ar_ready, .ar, .r_valid, .r_ready, .r,
        .res_valid (axi_res_valid), .res_ready, .res (axi_res)
    );

    lsu_clint clint_i (
        .clk, .arst_n,
        .go_valid (clint_go_valid), .go_ready (clint_go_ready),
        .go_wdata (clint_go_wdata), .go_hi (clint_go_hi),
        .go_write (clint_go_write), .go_err (clint_go_err),
        .res_valid (clint_res_valid), .res_ready, .res (clint_res)
    );

    lsu_rsp_merge merge_i (
        .clk, .arst_n, .fmt,
        .axi_res_valid, .axi_res, .clint_res_valid, .clint_res,
        .res_ready, .rsp_valid, .rsp_ready, .rsp, .retire
    );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module axi_mem_model #(
    parameter logic [31:0] ERR_BASE = 32'h0000_0f00,
    parameter logic [31:0] ERR_END  = 32'h0000_0f3f
) (
    input  wire                        clk,
    input  wire                        arst_n,
    // a set bit lets the matching ready go high this cycle
    input  wire [2:0]                  ready_rnd,
    input  wire                        aw_valid,
    output logic                       aw_ready,
    input  wire axi_lite_pkg::axi_aw_t aw,
    input  wire                        w_valid,
    output logic                       w_ready,
    input  wire axi_lite_pkg::axi_w_t  w,
    output logic                       b_valid,
    input  wire                        b_ready,
    output axi_lite_pkg::axi_b_t       b,
    input  wire                        ar_valid,
    output logic                       ar_ready,
    input  wire axi_lite_pkg::axi_ar_t ar,
    output logic                       r_valid,
    input  wire                        r_ready,
    output axi_lite_pkg::axi_r_t       r
);
    import axi_lite_pkg::*;

    logic [7:0] mem [0:4095];
    logic       aw_got;
    logic       w_got;
    logic       b_issue;
    axi_aw_t    aw_q;
    axi_w_t     w_q;

    function automatic logic in_err_range(input logic [31:0] addr);
        return (addr >= ERR_BASE) && (addr <= ERR_END);
    endfunction

    // preload pattern over the whole byte address
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[12'(i)] = 8'(i ^ (i >> 5));
        end
    end

    assign aw_ready = !aw_got && !b_valid && ready_rnd[0];
    assign w_ready  = !w_got && !b_valid && ready_rnd[1];
    assign ar_ready = !r_valid && ready_rnd[2];
    // respond once address and data are both in
    assign b_issue  = aw_got && w_got && !b_valid;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_got <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_got <= 1'b1;
            end
            if (b_issue) begin
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            aw_q <= aw;
        end
        if (w_valid && w_ready) begin
            w_q <= w;
        end
        if (b_issue) begin
            b.resp <= in_err_range(aw_q.addr) ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
            // error range is never written
            if (!in_err_range(aw_q.addr)) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_q.strb[i]) begin
                        mem[{aw_q.addr[11:2], 2'(i)}] = w_q.data[8*i +: 8];
                    end
                end
            end
        end
        if (ar_valid && ar_ready) begin
            r.resp <= in_err_range(ar.addr) ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
            r.data <= {mem[{ar.addr[11:2], 2'd3}], mem[{ar.addr[11:2], 2'd2}],
                       mem[{ar.addr[11:2], 2'd1}], mem[{ar.addr[11:2], 2'd0}]};
        end
    end

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_tb;
    import lsu_req_pkg::*;
    import axi_lite_pkg::*;

    localparam logic [31:0] SEED       = 32'h34ba_a946;
    localparam logic [31:0] ERR_BASE   = 32'h0000_0f00;
    localparam logic [31:0] ERR_END    = 32'h0000_0f3f;
    localparam logic [31:0] MEM_BASE   = 32'h0000_0100;
    localparam int          WAIT_LIMIT = 200;
    localparam int          N_RANDOM   = 400;
    // how rdata of a response is judged
    localparam logic [1:0]  CHK_NONE   = 2'd0;
    localparam logic [1:0]  CHK_EXACT  = 2'd1;
    localparam logic [1:0]  CHK_MIN    = 2'd2;

    logic        clk;
    logic        arst_n;
    logic        arst_q = 1'b0;
    logic        req_valid;
    logic        req_ready;
    mem_req_t    req;
    logic        rsp_valid;
    logic        rsp_ready;
    mem_rsp_t    rsp;
    logic        aw_valid;
    logic        aw_ready;
    axi_aw_t     aw;
    logic        w_valid;
    logic        w_ready;
    axi_w_t      w;
    logic        b_valid;
    logic        b_ready;
    axi_b_t      b;
    logic        ar_valid;
    logic        ar_ready;
    axi_ar_t     ar;
    logic        r_valid;
    logic        r_ready;
    axi_r_t      r;

    logic [31:0] stim_state = SEED;
    logic [31:0] bp_state = SEED;
    logic [7:0]  ref_mem [0:4095];
    logic [31:0] lo_floor = 32'd0;
    logic [31:0] hi_floor = 32'd0;
    logic [1:0]  exp_kind = CHK_NONE;
    logic [31:0] exp_rdata = 32'd0;
    logic        exp_err = 1'b0;
    logic [31:0] exp_addr = 32'd0;
    logic [2:0]  exp_size = 3'd0;
    logic        busy;
    logic        clint_busy;

    lsu_top lsu_top_i (.*);

    axi_mem_model #(.ERR_BASE(ERR_BASE), .ERR_END(ERR_END)) mem_i (
        .*,
        .ready_rnd (bp_state[31:29])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        bp_state <= lcg_next(bp_state);
        arst_q   <= arst_n;
    end

    // tracks the access in flight from accept to response handshake
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            clint_busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy       <= 1'b1;
            clint_busy <= (req.addr >= `LSU_CLINT_BASE) && (req.addr <= `LSU_CLINT_END);
        end else if (rsp_valid && rsp_ready) begin
            busy       <= 1'b0;
            clint_busy <= 1'b0;
        end
    end

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        abort_run("a check on the DUT outputs failed");
    endtask

    a_reset_quiet: assert property (@(posedge clk)
        (!arst_n || !arst_q) |-> !(rsp_valid || aw_valid || w_valid || ar_valid))
        else report_error("valid output high during or just after reset");

    a_rdata_exact: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp_ready && exp_kind == CHK_EXACT) |-> (rsp.rdata == exp_rdata))
        else report_error($sformatf("rdata %h, expected %h", rsp.rdata, exp_rdata));

    a_rdata_min: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp_ready && exp_kind == CHK_MIN) |-> (rsp.rdata >= exp_rdata))
        else report_error($sformatf("mtime word %h below %h", rsp.rdata, exp_rdata));

    a_err: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp_ready) |-> (rsp.err == exp_err))
        else report_error($sformatf("err %b, expected %b", rsp.err, exp_err));

    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        $past(rsp_valid && !rsp_ready) |-> (rsp_valid && $stable(rsp)))
        else report_error("response changed or dropped while stalled");

    a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !req_ready)
        else report_error("req_ready high while an access is in flight");

    a_clint_no_axi: assert property (@(posedge clk) disable iff (!arst_n)
        clint_busy |-> !(aw_valid || w_valid || ar_valid))
        else report_error("AXI valid raised for a CLINT access");

    a_aw_payload: assert property (@(posedge clk) disable iff (!arst_n)
        aw_valid |-> (aw.addr == exp_addr && aw.size == exp_size))
        else report_error($sformatf("aw addr %h size %0d, expected addr %h size %0d",
                                    aw.addr, aw.size, exp_addr, exp_size));

    a_ar_payload: assert property (@(posedge clk) disable iff (!arst_n)
        ar_valid |-> (ar.addr == exp_addr && ar.size == exp_size))
        else report_error($sformatf("ar addr %h size %0d, expected addr %h size %0d",
                                    ar.addr, ar.size, exp_addr, exp_size));

    a_resp_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (b_ready && r_ready))
        else report_error("b_ready or r_ready low outside reset");

    task automatic draw(output logic [31:0] v);
        stim_state = lcg_next(stim_state);
        v = stim_state;
    endtask

    function automatic logic [31:0] align_to_size(input logic [31:0] a, input access_size_e sz);
        case (sz)
            SIZE_BYTE: return a;
            SIZE_HALF: return a & ~32'd1;
            default:   return a & ~32'd3;
        endcase
    endfunction

    // AXI size code for 1, 2 or 4 bytes
    function automatic logic [2:0] axi_size_code(input access_size_e sz);
        case (sz)
            SIZE_BYTE: return 3'd0;
            SIZE_HALF: return 3'd1;
            default:   return 3'd2;
        endcase
    endfunction

    // little-endian load extended by size and sign
    function automatic logic [31:0] ref_load(input logic [31:0] a, input access_size_e sz,
                                             input logic sign);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a[11:0]];
        b1 = ref_mem[a[11:0] + 12'd1];
        case (sz)
            SIZE_BYTE: return {{24{sign & b0[7]}}, b0};
            SIZE_HALF: return {{16{sign & b1[7]}}, b1, b0};
            default:   return {ref_mem[a[11:0] + 12'd3], ref_mem[a[11:0] + 12'd2], b1, b0};
        endcase
    endfunction

    task automatic ref_store(input logic [31:0] a, input access_size_e sz, input logic [31:0] d);
        int n;
        n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a[11:0] + 12'(i)] = d[8*i +: 8];
        end
    endtask

    task automatic issue_request(input mem_req_t rq);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= rq;
        @(negedge clk);
        while (!req_ready) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("request was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // rsp_ready toggles at random while waiting
    task automatic wait_response(output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("no response arrived for an accepted request");
            @(posedge clk);
            rsp_ready <= bp_state[28];
            @(negedge clk);
        end
        rdata = rsp.rdata;
        @(posedge clk);
        rsp_ready <= 1'b0;
    endtask

    task automatic do_access(input logic [31:0] addr, input access_size_e size,
                             input logic write, input logic sign, input logic [31:0] wdata);
        mem_req_t    rq;
        logic        in_clint;
        logic        in_err;
        logic        hi;
        logic [31:0] got;
        in_clint = (addr >= `LSU_CLINT_BASE) && (addr <= `LSU_CLINT_END);
        in_err   = (addr >= ERR_BASE) && (addr <= ERR_END);
        hi       = addr[2];
        rq = '{addr: addr, wdata: wdata, size: size, write: write, sign: sign};
        exp_addr <= addr;
        exp_size <= axi_size_code(size);
        if (write) begin
            exp_kind  <= CHK_EXACT;
            exp_rdata <= 32'd0;
            exp_err   <= in_err || (in_clint && size != SIZE_WORD);
        end else if (in_clint) begin
            exp_kind  <= CHK_MIN;
            exp_rdata <= hi ? hi_floor : lo_floor;
            exp_err   <= 1'b0;
        end else begin
            exp_kind  <= in_err ? CHK_NONE : CHK_EXACT;
            exp_rdata <= ref_load(addr, size, sign);
            exp_err   <= in_err;
        end
        issue_request(rq);
        wait_response(got);
        if (write && !in_clint && !in_err) begin
            ref_store(addr, size, wdata);
        end
        if (in_clint && write && size == SIZE_WORD) begin
            if (hi) begin
                hi_floor = wdata;
            end else begin
                lo_floor = wdata;
            end
        end
        // low word must keep counting up
        if (in_clint && !write && !hi) begin
            lo_floor = got + 32'd1;
        end
    endtask

    initial begin
        logic [31:0]  rv;
        logic [31:0]  dv;
        access_size_e sz;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[12'(i)] = 8'(i ^ (i >> 5));
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // mtime through the CLINT window
        do_access(`LSU_CLINT_BASE, SIZE_WORD, 1'b1, 1'b0, 32'h0001_0000);
        do_access(`LSU_CLINT_BASE, SIZE_WORD, 1'b0, 1'b0, 32'd0);
        do_access(`LSU_CLINT_BASE, SIZE_WORD, 1'b0, 1'b0, 32'd0);
        do_access(`LSU_CLINT_BASE + 32'd4, SIZE_WORD, 1'b1, 1'b0, 32'h0000_0003);
        do_access(`LSU_CLINT_BASE + 32'd4, SIZE_WORD, 1'b0, 1'b0, 32'd0);
        do_access(`LSU_CLINT_BASE + 32'd2, SIZE_HALF, 1'b1, 1'b0, 32'h0000_beef);
        do_access(`LSU_CLINT_BASE + 32'd5, SIZE_BYTE, 1'b1, 1'b0, 32'h0000_0077);

        for (int n = 0; n < N_RANDOM; n++) begin
            draw(rv);
            draw(dv);
            sz = (rv[26:25] == 2'd0) ? SIZE_BYTE : (rv[26:25] == 2'd1) ? SIZE_HALF : SIZE_WORD;
            case (rv[30:28])
                3'd5: do_access(ERR_BASE + align_to_size({26'd0, rv[21:16]}, sz), sz,
                                rv[27], rv[24], dv);
                3'd6: do_access(`LSU_CLINT_BASE + {29'd0, rv[16], 2'b00}, SIZE_WORD,
                                rv[27], 1'b0, {1'b0, dv[30:0]});
                // partial store into the mtime window
                3'd7: do_access(`LSU_CLINT_BASE + align_to_size({29'd0, rv[18:16]},
                                rv[25] ? SIZE_HALF : SIZE_BYTE),
                                rv[25] ? SIZE_HALF : SIZE_BYTE, 1'b1, 1'b0, dv);
                default: do_access(MEM_BASE + align_to_size({26'd0, rv[21:16]}, sz), sz,
                                   rv[27], rv[24], dv);
            endcase
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+src
src/lsu_req_pkg.sv
src/axi_lite_pkg.sv
src/lsu_req_route.sv
src/lsu_axi_master.sv
src/lsu_clint.sv
src/lsu_rsp_merge.sv
src/lsu_top.sv
dv/axi_mem_model.sv
dv/lsu_tb.sv

/* Makefile */
SRCS := $(filter-out +incdir+%,$(shell cat files.f)) src/lsu_consts.svh

.PHONY: run clean

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb

obj_dir/Vlsu_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module lsu_tb -f files.f

clean:
	rm -rf obj_dir
